/* src/icache_pkg.sv */
package icache_pkg;

  //////////////////////////////
  // Line geometry
  //////////////////////////////

  // Words per line, byte offset bits in a line
  localparam int LINE_WORDS     = 4;
  localparam int LINE_OFFS_BITS = 4;

  // Plain vectors with a meaning
  typedef logic [31:0]               adr_t;
  typedef logic [31:0]               word_t;
  typedef logic [LINE_WORDS*32-1:0]  line_t;

  //////////////////////////////
  // Fetch side
  //////////////////////////////

  typedef struct packed {
    adr_t adr;
    logic cacheable;
  } fetch_req_t;

  typedef struct packed {
    adr_t  pc;
    word_t parcel;
    logic  error;
    logic  misaligned;
  } fetch_rsp_t;

  //////////////////////////////
  // AXI4-Lite read channels
  //////////////////////////////

  typedef struct packed {
    adr_t       addr;
    logic [2:0] prot;
  } axi_ar_t;

  typedef struct packed {
    word_t      data;
    logic [1:0] resp;
  } axi_r_t;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // Hit stage states
  typedef enum logic [2:0] {
    ARMED,
    FLUSH,
    NONCACHEABLE,
    WAIT4FILL,
    RECOVER
  } memfsm_t;

  // Commands to the bus master
  typedef enum logic [1:0] {
    NOP,
    READLINE,
    READWORD
  } fill_cmd_t;

endpackage

/* src/icache_lookup.sv */
module icache_lookup #(
  parameter  int SETS     = 16,
  localparam int IDX_BITS = $clog2(SETS)
)
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Fetch unit
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  input  icache_pkg::fetch_req_t fetch_req_i,

  // Hit stage busy, keep the held request
  input  logic                   hold_i,

  // Memory read index
  output logic [IDX_BITS-1:0]    rd_idx_o,

  // Registered request to the hit stage
  output logic                   req_valid_o,
  output icache_pkg::fetch_req_t req_o
);

  import icache_pkg::*;

  logic run_q;
  logic accept;

  // Register is free whenever the hit stage consumes it
  assign fetch_ready_o = run_q & ~hold_i;
  assign accept        = fetch_valid_i & fetch_ready_o;

  // Control state
  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      run_q       <= 1'b0;
      req_valid_o <= 1'b0;
    end
    else
    begin
      // Open for requests from the first cycle after reset
      run_q <= 1'b1;
      if (!hold_i)
        req_valid_o <= accept;
    end

  // One-entry request register
  always_ff @(posedge clk_i)
    if (accept)
      req_o <= fetch_req_i;

  // Incoming index on accept, held index while replaying
  assign rd_idx_o = hold_i ? req_o.adr[LINE_OFFS_BITS +: IDX_BITS]
                           : fetch_req_i.adr[LINE_OFFS_BITS +: IDX_BITS];

endmodule

/* src/icache_mem.sv */
module icache_mem #(
  parameter  int SETS     = 16,
  localparam int IDX_BITS = $clog2(SETS),
  localparam int TAG_BITS = $bits(icache_pkg::adr_t) - IDX_BITS - icache_pkg::LINE_OFFS_BITS
)
(
  input  logic                clk_i,
  input  logic                rst_ni,

  // Read port, data one cycle later
  input  logic [IDX_BITS-1:0] rd_idx_i,
  output logic [TAG_BITS-1:0] rd_tag_o,
  output logic                rd_valid_o,
  output icache_pkg::line_t   rd_line_o,

  // Line write port
  input  logic                we_i,
  input  logic [IDX_BITS-1:0] wr_idx_i,
  input  logic [TAG_BITS-1:0] wr_tag_i,
  input  icache_pkg::line_t   wr_line_i,
  input  logic                wr_valid_i,

  // Cache flush
  input  logic                flush_start_i,
  output logic                flush_busy_o
);

  import icache_pkg::*;

  //////////////////////////////
  // Storage
  //////////////////////////////

  logic [TAG_BITS-1:0] tag_mem [SETS];
  line_t               dat_mem [SETS];
  logic [SETS-1:0]     valid_q;

  logic [IDX_BITS-1:0] flush_cnt_q;

  // Tag and data arrays, synchronous read
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      tag_mem[wr_idx_i] <= wr_tag_i;
      dat_mem[wr_idx_i] <= wr_line_i;
    end
    // Read during write returns old contents
    rd_tag_o  <= tag_mem[rd_idx_i];
    rd_line_o <= dat_mem[rd_idx_i];
  end

  //////////////////////////////
  // Valid bits and flush
  //////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      valid_q      <= '0;
      rd_valid_o   <= 1'b0;
      flush_busy_o <= 1'b0;
      flush_cnt_q  <= '0;
    end
    else
    begin
      rd_valid_o <= valid_q[rd_idx_i];

      // Clear one line per cycle
      if (flush_busy_o)
      begin
        valid_q[flush_cnt_q] <= 1'b0;
        flush_cnt_q          <= flush_cnt_q + 1'b1;
        if (flush_cnt_q == IDX_BITS'(SETS-1))
          flush_busy_o <= 1'b0;
      end
      else if (flush_start_i)
      begin
        flush_busy_o <= 1'b1;
        flush_cnt_q  <= '0;
      end

      // Error fills write an invalid line
      if (we_i)
        valid_q[wr_idx_i] <= wr_valid_i;
    end

endmodule

/* src/icache_hit.sv */
module icache_hit #(
  parameter  int SETS      = 16,
  localparam int IDX_BITS  = $clog2(SETS),
  localparam int TAG_BITS  = $bits(icache_pkg::adr_t) - IDX_BITS - icache_pkg::LINE_OFFS_BITS,
  localparam int WIDX_BITS = $clog2(icache_pkg::LINE_WORDS)
)
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Lookup stage
  input  logic                   req_valid_i,
  input  icache_pkg::fetch_req_t req_i,
  output logic                   hold_o,

  // Cache memory read data
  input  logic [TAG_BITS-1:0]    rd_tag_i,
  input  logic                   rd_valid_i,
  input  icache_pkg::line_t      rd_line_i,

  // Cache flush
  input  logic                   cacheflush_req_i,
  output logic                   flush_start_o,
  input  logic                   flush_busy_i,

  // Bus master
  output icache_pkg::fill_cmd_t  fill_cmd_o,
  output icache_pkg::adr_t       fill_adr_o,
  input  logic                   fill_word_we_i,
  input  logic [WIDX_BITS-1:0]   fill_word_idx_i,
  input  icache_pkg::word_t      fill_word_i,
  input  logic                   fill_done_i,
  input  logic                   fill_err_i,

  // Cache memory line write
  output logic                   line_we_o,
  output logic [IDX_BITS-1:0]    wr_idx_o,
  output logic [TAG_BITS-1:0]    wr_tag_o,
  output icache_pkg::line_t      wr_line_o,
  output logic                   wr_valid_o,

  // Fetch response
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o
);

  import icache_pkg::*;

  localparam int WORD_BITS = $bits(word_t);

  memfsm_t             state_q;
  fetch_req_t          pend_q;
  line_t               line_buf_q;
  line_t               line_next;
  logic [TAG_BITS-1:0] req_tag;
  logic                armed;
  logic                cache_hit;
  logic                take_hit;
  logic                take_miss;
  logic                take_nc;
  logic                nc_done;

  // Parcel from a line by word offset
  function automatic word_t sel_word(line_t line, logic [WIDX_BITS-1:0] offs);
    sel_word = line[offs*WORD_BITS +: WORD_BITS];
  endfunction

  // Response with misaligned from pc bits 1:0
  function automatic fetch_rsp_t make_rsp(adr_t pc, word_t parcel, logic err);
    fetch_rsp_t rsp;
    rsp.pc         = pc;
    rsp.parcel     = parcel;
    rsp.error      = err;
    rsp.misaligned = |pc[1:0];
    return rsp;
  endfunction

  //////////////////////////////
  // Lookup decode
  //////////////////////////////

  assign req_tag   = req_i.adr[$bits(adr_t)-1 -: TAG_BITS];
  assign cache_hit = rd_valid_i & (rd_tag_i == req_tag);
  assign armed     = (state_q == ARMED);

  assign take_hit  = armed & req_valid_i &  req_i.cacheable &  cache_hit;
  assign take_miss = armed & req_valid_i &  req_i.cacheable & ~cache_hit;
  assign take_nc   = armed & req_valid_i & ~req_i.cacheable;
  assign nc_done   = (state_q == NONCACHEABLE) & fill_done_i;

  // Flush only with no lookup in flight
  assign flush_start_o = armed & ~req_valid_i & cacheflush_req_i;

  // Lookup stage waits while busy
  assign hold_o = ~armed;

  //////////////////////////////
  // Memory interface FSM
  //////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      state_q     <= ARMED;
      fill_cmd_o  <= NOP;
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_o <= take_hit | nc_done | (state_q == RECOVER);
      unique case (state_q)
        ARMED       : if (flush_start_o)
                        state_q <= FLUSH;
                      else if (take_miss)
                      begin
                        state_q    <= WAIT4FILL;
                        fill_cmd_o <= READLINE;
                      end
                      else if (take_nc)
                      begin
                        state_q    <= NONCACHEABLE;
                        fill_cmd_o <= READWORD;
                      end
        FLUSH       : if (!flush_busy_i)
                        state_q <= ARMED;
        NONCACHEABLE: if (fill_done_i)
                      begin
                        state_q    <= ARMED;
                        fill_cmd_o <= NOP;
                      end
        WAIT4FILL   : if (fill_done_i)
                      begin
                        state_q    <= RECOVER;
                        fill_cmd_o <= NOP;
                      end
        // Memory re-reads the held index here
        RECOVER     : state_q <= ARMED;
        default     : state_q <= ARMED;
      endcase
    end

  // Current beat merged into the line buffer
  always_comb
  begin
    line_next = line_buf_q;
    if (fill_word_we_i)
      line_next[fill_word_idx_i*WORD_BITS +: WORD_BITS] = fill_word_i;
  end

  // Payload registers
  always_ff @(posedge clk_i)
  begin
    if (take_miss || take_nc)
    begin
      pend_q     <= req_i;
      fill_adr_o <= take_miss ? {req_i.adr[31:LINE_OFFS_BITS], {LINE_OFFS_BITS{1'b0}}}
                              : {req_i.adr[31:2], 2'b00};
    end

    if (state_q == WAIT4FILL)
      line_buf_q <= line_next;

    // Hit, single read or finished fill
    if (take_hit)
      rsp_o <= make_rsp(req_i.adr, sel_word(rd_line_i, req_i.adr[2 +: WIDX_BITS]), 1'b0);
    else if (nc_done)
      rsp_o <= make_rsp(pend_q.adr, fill_word_i, fill_err_i);
    else if (state_q == RECOVER)
      rsp_o <= make_rsp(pend_q.adr, sel_word(line_buf_q, pend_q.adr[2 +: WIDX_BITS]),
                        fill_err_i);
  end

  //////////////////////////////
  // Line write
  //////////////////////////////

  assign line_we_o  = (state_q == WAIT4FILL) & fill_done_i;
  assign wr_idx_o   = pend_q.adr[LINE_OFFS_BITS +: IDX_BITS];
  assign wr_tag_o   = pend_q.adr[$bits(adr_t)-1 -: TAG_BITS];
  assign wr_line_o  = line_next;
  assign wr_valid_o = ~fill_err_i;

endmodule

/* src/icache_fill.sv */
module icache_fill (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  // Command from the hit stage, held until done
  input  icache_pkg::fill_cmd_t                  fill_cmd_i,
  input  icache_pkg::adr_t                       fill_adr_i,

  // AXI4-Lite AR channel
  output logic                                   ar_valid_o,
  input  logic                                   ar_ready_i,
  output icache_pkg::axi_ar_t                    ar_o,

  // AXI4-Lite R channel
  input  logic                                   r_valid_i,
  output logic                                   r_ready_o,
  input  icache_pkg::axi_r_t                     r_i,

  // Returned beats
  output logic                                   fill_word_we_o,
  output logic [$clog2(icache_pkg::LINE_WORDS)-1:0] fill_word_idx_o,
  output icache_pkg::word_t                      fill_word_o,
  output logic                                   fill_done_o,
  output logic                                   fill_err_o
);

  import icache_pkg::*;

  localparam int         WIDX_BITS  = $clog2(LINE_WORDS);
  // Unprivileged, secure, instruction access
  localparam logic [2:0] PROT_INSTR = 3'b100;

  logic                 busy_q;
  logic [WIDX_BITS-1:0] beat_q;
  logic                 single;
  logic                 start;
  logic                 last_beat;
  logic                 r_hsk;

  assign single    = (fill_cmd_i == READWORD);
  // No restart in the done cycle, command still high
  assign start     = ~busy_q & ~fill_done_o & (fill_cmd_i != NOP);
  assign last_beat = single | (beat_q == WIDX_BITS'(LINE_WORDS-1));
  assign r_hsk     = r_ready_o & r_valid_i;

  // Line beats go out in increasing word order
  assign ar_o.addr = single ? fill_adr_i
                            : {fill_adr_i[31:LINE_OFFS_BITS], beat_q, 2'b00};
  assign ar_o.prot = PROT_INSTR;

  //////////////////////////////
  // Beat sequencer
  //////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      busy_q         <= 1'b0;
      beat_q         <= '0;
      ar_valid_o     <= 1'b0;
      r_ready_o      <= 1'b0;
      fill_word_we_o <= 1'b0;
      fill_done_o    <= 1'b0;
      fill_err_o     <= 1'b0;
    end
    else
    begin
      fill_word_we_o <= 1'b0;
      fill_done_o    <= 1'b0;

      if (start)
      begin
        busy_q     <= 1'b1;
        beat_q     <= '0;
        ar_valid_o <= 1'b1;
        fill_err_o <= 1'b0;
      end

      // Address taken, wait for data
      if (ar_valid_o && ar_ready_i)
      begin
        ar_valid_o <= 1'b0;
        r_ready_o  <= 1'b1;
      end

      // Data beat, next read or finish
      if (r_hsk)
      begin
        r_ready_o      <= 1'b0;
        fill_word_we_o <= 1'b1;
        fill_err_o     <= fill_err_o | (r_i.resp != AXI_RESP_OKAY);
        if (last_beat)
        begin
          busy_q      <= 1'b0;
          fill_done_o <= 1'b1;
        end
        else
        begin
          beat_q     <= beat_q + 1'b1;
          ar_valid_o <= 1'b1;
        end
      end
    end

  // Beat data
  always_ff @(posedge clk_i)
    if (r_hsk)
    begin
      fill_word_o     <= r_i.data;
      fill_word_idx_o <= beat_q;
    end

endmodule

/* src/icache_top.sv */
module icache_top #(
  parameter int SETS = 16
)
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Fetch side
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  input  logic                   cacheflush_req_i,

  // AXI4-Lite read master
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output icache_pkg::axi_ar_t    ar_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  icache_pkg::axi_r_t     r_i
);

  import icache_pkg::*;

  localparam int IDX_BITS  = $clog2(SETS);
  localparam int TAG_BITS  = $bits(adr_t) - IDX_BITS - LINE_OFFS_BITS;
  localparam int WIDX_BITS = $clog2(LINE_WORDS);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  // Lookup to hit stage
  logic                 hold;
  logic                 req_valid;
  fetch_req_t           req;
  logic [IDX_BITS-1:0]  rd_idx;

  // Memory read and write
  logic [TAG_BITS-1:0]  rd_tag;
  logic                 rd_valid;
  line_t                rd_line;
  logic                 line_we;
  logic [IDX_BITS-1:0]  wr_idx;
  logic [TAG_BITS-1:0]  wr_tag;
  line_t                wr_line;
  logic                 wr_valid;
  logic                 flush_start;
  logic                 flush_busy;

  // Hit stage to bus master
  fill_cmd_t            fill_cmd;
  adr_t                 fill_adr;
  logic                 fill_word_we;
  logic [WIDX_BITS-1:0] fill_word_idx;
  word_t                fill_word;
  logic                 fill_done;
  logic                 fill_err;

  icache_lookup #(
    .SETS (SETS)
  ) icache_lookup_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_req_i   (fetch_req_i),
    .hold_i        (hold),
    .rd_idx_o      (rd_idx),
    .req_valid_o   (req_valid),
    .req_o         (req)
  );

  icache_mem #(
    .SETS (SETS)
  ) icache_mem_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_idx_i      (rd_idx),
    .rd_tag_o      (rd_tag),
    .rd_valid_o    (rd_valid),
    .rd_line_o     (rd_line),
    .we_i          (line_we),
    .wr_idx_i      (wr_idx),
    .wr_tag_i      (wr_tag),
    .wr_line_i     (wr_line),
    .wr_valid_i    (wr_valid),
    .flush_start_i (flush_start),
    .flush_busy_o  (flush_busy)
  );

  icache_hit #(
    .SETS (SETS)
  ) icache_hit_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid),
    .req_i            (req),
    .hold_o           (hold),
    .rd_tag_i         (rd_tag),
    .rd_valid_i       (rd_valid),
    .rd_line_i        (rd_line),
    .cacheflush_req_i (cacheflush_req_i),
    .flush_start_o    (flush_start),
    .flush_busy_i     (flush_busy),
    .fill_cmd_o       (fill_cmd),
    .fill_adr_o       (fill_adr),
    .fill_word_we_i   (fill_word_we),
    .fill_word_idx_i  (fill_word_idx),
    .fill_word_i      (fill_word),
    .fill_done_i      (fill_done),
    .fill_err_i       (fill_err),
    .line_we_o        (line_we),
    .wr_idx_o         (wr_idx),
    .wr_tag_o         (wr_tag),
    .wr_line_o        (wr_line),
    .wr_valid_o       (wr_valid),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_o            (rsp_o)
  );

  icache_fill icache_fill_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fill_cmd_i      (fill_cmd),
    .fill_adr_i      (fill_adr),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_o            (ar_o),
    .r_valid_i       (r_valid_i),
    .r_ready_o       (r_ready_o),
    .r_i             (r_i),
    .fill_word_we_o  (fill_word_we),
    .fill_word_idx_o (fill_word_idx),
    .fill_word_o     (fill_word),
    .fill_done_o     (fill_done),
    .fill_err_o      (fill_err)
  );

endmodule

/* verif/icache_sva.sv */
module icache_sva (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Bus master side
  input  logic                ar_valid_i,
  input  logic                ar_ready_i,
  input  icache_pkg::axi_ar_t ar_i,

  // Hit stage side
  input  logic                rsp_valid_i,
  input  logic                fill_active_i,
  input  logic                flush_busy_i,
  input  logic                hold_i
);

  int unsigned ar_errs    = 0;
  int unsigned rsp_errs   = 0;
  int unsigned flush_errs = 0;
  int unsigned err_cnt;

  // Failures over all three properties
  assign err_cnt = ar_errs + rsp_errs + flush_errs;

  // AR held stable until the slave takes it
  ar_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
  else
  begin
    $error("AR request dropped or changed before its handshake");
    ar_errs++;
  end

  // No response while a fill command is open
  rsp_in_fill_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_active_i |-> !rsp_valid_i)
  else
  begin
    $error("Fetch response raised while a fill was active");
    rsp_errs++;
  end

  // Fetch side closed while valid bits are cleared
  flush_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_busy_i |-> hold_i)
  else
  begin
    $error("Fetch side open during a cache flush");
    flush_errs++;
  end

endmodule

// Hit stage with the bus ports tied off
bind icache_hit icache_sva hit_sva_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .ar_valid_i    (1'b0),
  .ar_ready_i    (1'b0),
  .ar_i          ('0),
  .rsp_valid_i   (rsp_valid_o),
  .fill_active_i (fill_cmd_o != icache_pkg::NOP),
  .flush_busy_i  (flush_busy_i),
  .hold_i        (hold_o)
);

// Bus master with the hit stage ports tied off
bind icache_fill icache_sva fill_sva_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .ar_valid_i    (ar_valid_o),
  .ar_ready_i    (ar_ready_i),
  .ar_i          (ar_o),
  .rsp_valid_i   (1'b0),
  .fill_active_i (1'b0),
  .flush_busy_i  (1'b0),
  .hold_i        (1'b0)
);

/* verif/icache_tb.sv */
module icache_tb;

  import icache_pkg::*;

  localparam int    SETS        = 16;
  localparam int    NUM_TESTS   = 12;
  localparam int    TEST_CYCLES = 200;
  // One slot per table entry plus the back-to-back pair
  localparam int    MAX_CYCLES  = TEST_CYCLES * (NUM_TESTS + 1);
  localparam word_t DATA_KEY    = 32'h5A5A_0000;

  typedef struct {
    string name;
    adr_t  adr;
    logic  cacheable;
    logic  flush;
    int    reads;
    logic  err;
  } test_t;

  logic       clk_i            = 1'b0;
  logic       rst_ni           = 1'b0;
  logic       fetch_valid_i    = 1'b0;
  logic       fetch_ready_o;
  fetch_req_t fetch_req_i      = '0;
  logic       rsp_valid_o;
  fetch_rsp_t rsp_o;
  logic       cacheflush_req_i = 1'b0;
  logic       ar_valid_o;
  logic       ar_ready_i       = 1'b0;
  axi_ar_t    ar_o;
  logic       r_valid_i        = 1'b0;
  logic       r_ready_o;
  axi_r_t     r_i              = '0;

  // Bus model state
  integer  seed     = 770;
  int      ar_delay = 0;
  int      r_delay  = 0;
  logic    r_pend   = 1'b0;
  adr_t    rd_adr   = '0;
  axi_ar_t ar_log [$];
  int      cycles   = 0;

  // Failures over both bound checkers
  int unsigned sva_errs;

  // Name, address, cacheable, flush first, AR reads, error
  test_t tests [NUM_TESTS] = '{
    '{"cold_miss",        32'h0000_1004, 1'b1, 1'b0, 4, 1'b0},
    '{"hit_same_line",    32'h0000_100C, 1'b1, 1'b0, 0, 1'b0},
    '{"nc_read",          32'h0000_2008, 1'b0, 1'b0, 1, 1'b0},
    '{"nc_repeat",        32'h0000_2008, 1'b0, 1'b0, 1, 1'b0},
    '{"conflict_fill",    32'h0000_3000, 1'b1, 1'b0, 4, 1'b0},
    '{"conflict_back",    32'h0000_1008, 1'b1, 1'b0, 4, 1'b0},
    '{"hit_before_flush", 32'h0000_1000, 1'b1, 1'b0, 0, 1'b0},
    '{"after_flush",      32'h0000_1000, 1'b1, 1'b1, 4, 1'b0},
    '{"bus_error",        32'h8000_0040, 1'b1, 1'b0, 4, 1'b1},
    '{"error_refetch",    32'h8000_0044, 1'b1, 1'b0, 4, 1'b1},
    '{"misaligned",       32'h0000_1002, 1'b1, 1'b0, 0, 1'b0},
    '{"nc_error",         32'h8000_0100, 1'b0, 1'b0, 1, 1'b1}
  };

  icache_top #(
    .SETS (SETS)
  ) icache_top_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_ready_o    (fetch_ready_o),
    .fetch_req_i      (fetch_req_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_o            (rsp_o),
    .cacheflush_req_i (cacheflush_req_i),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .ar_o             (ar_o),
    .r_valid_i        (r_valid_i),
    .r_ready_o        (r_ready_o),
    .r_i              (r_i)
  );

  always #10 clk_i = ~clk_i;

  assign sva_errs = icache_top_i.icache_hit_i.hit_sva_i.err_cnt
                  + icache_top_i.icache_fill_i.fill_sva_i.err_cnt;

  // Memory word at an address aligned down to the word
  function automatic word_t model_word(adr_t adr);
    return {adr[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  //////////////////////////////
  // AXI4-Lite read slave
  //////////////////////////////

  always @(posedge clk_i)
    if (rst_ni)
    begin
      if (ar_valid_o && ar_ready_i)
      begin
        ar_ready_i <= 1'b0;
        rd_adr      = ar_o.addr;
        ar_log.push_back(ar_o);
        r_pend      = 1'b1;
        r_delay     = $unsigned($random(seed)) % 4;
        ar_delay    = $unsigned($random(seed)) % 4;
      end
      else if (ar_valid_o)
      begin
        // Random wait before AR ready
        if (ar_delay == 0)
          ar_ready_i <= 1'b1;
        else
          ar_delay--;
      end

      if (r_valid_i && r_ready_o)
      begin
        r_valid_i <= 1'b0;
        r_pend     = 1'b0;
      end
      else if (r_pend && !r_valid_i)
      begin
        // Upper half of the map answers SLVERR
        if (r_delay == 0)
        begin
          r_valid_i <= 1'b1;
          r_i       <= '{data: model_word(rd_adr),
                         resp: rd_adr[31] ? AXI_RESP_SLVERR : AXI_RESP_OKAY};
        end
        else
          r_delay--;
      end
    end

  // Watchdog
  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("Timeout: no fetch response within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Run stopped by the watchdog");
    end
  end

  // Bound assertion failures end the run at once
  always @(negedge clk_i)
    if (sva_errs != 0)
    begin
      $display("Assertion failures seen: %0d", sva_errs);
      $display("** FAIL **");
      $fatal(1, "Run stopped by a failed assertion");
    end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first mismatch");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic verify_adr(input string name, input adr_t exp, input adr_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic match_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Whole response against the memory map rules
  task automatic score_rsp(input string name, input adr_t adr, input logic err,
                           input fetch_rsp_t rsp);
    verify_adr({name, "_pc"}, adr, rsp.pc);
    check_word({name, "_parcel"}, model_word(adr), rsp.parcel);
    match_flag({name, "_error"}, err, rsp.error);
    match_flag({name, "_misaligned"}, |adr[1:0], rsp.misaligned);
  endtask

  //////////////////////////////
  // Fetch side drivers
  //////////////////////////////

  // Latency counted in cycles from the accepting edge
  task automatic fetch_one(input adr_t req_adr, input logic req_cacheable,
                           output fetch_rsp_t rsp, output int lat);
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_req_i   <= '{adr: req_adr, cacheable: req_cacheable};
    @(negedge clk_i);
    while (!fetch_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    lat = 0;
    do
    begin
      @(negedge clk_i);
      lat++;
    end
    while (!rsp_valid_o);
    rsp = rsp_o;
  endtask

  // Two hits in consecutive cycles
  task automatic fetch_two_hits(input adr_t adr_a, input adr_t adr_b,
                                output fetch_rsp_t rsp_a, output fetch_rsp_t rsp_b);
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_req_i   <= '{adr: adr_a, cacheable: 1'b1};
    @(negedge clk_i);
    while (!fetch_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    fetch_req_i <= '{adr: adr_b, cacheable: 1'b1};
    @(negedge clk_i);
    match_flag("back_to_back_ready", 1'b1, fetch_ready_o);
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    @(negedge clk_i);
    match_flag("back_to_back_first_valid", 1'b1, rsp_valid_o);
    rsp_a = rsp_o;
    @(negedge clk_i);
    match_flag("back_to_back_second_valid", 1'b1, rsp_valid_o);
    rsp_b = rsp_o;
  endtask

  // One-cycle flush pulse and a count of the closed cycles
  task automatic pulse_flush(input string name);
    int low_cycles;
    @(posedge clk_i);
    cacheflush_req_i <= 1'b1;
    @(posedge clk_i);
    cacheflush_req_i <= 1'b0;
    low_cycles = 0;
    @(negedge clk_i);
    while (!fetch_ready_o)
    begin
      low_cycles++;
      @(negedge clk_i);
    end
    compare_count({name, "_flush_closed"}, SETS + 1, low_cycles);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    fetch_rsp_t  rsp;
    fetch_rsp_t  rsp_b;
    int          lat;
    int          base;
    adr_t        line_adr;
    adr_t        exp_adr;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    match_flag("reset_ready", 1'b0, fetch_ready_o);
    match_flag("reset_rsp_valid", 1'b0, rsp_valid_o);
    match_flag("reset_ar_valid", 1'b0, ar_valid_o);
    @(negedge clk_i);
    match_flag("ready_after_reset", 1'b1, fetch_ready_o);

    foreach (tests[i])
    begin
      if (tests[i].flush)
        pulse_flush(tests[i].name);
      base = ar_log.size();
      fetch_one(tests[i].adr, tests[i].cacheable, rsp, lat);
      compare_count({tests[i].name, "_reads"}, tests[i].reads, ar_log.size() - base);
      // Line reads at increasing word addresses and single reads at the word
      line_adr = {tests[i].adr[31:LINE_OFFS_BITS], {LINE_OFFS_BITS{1'b0}}};
      for (int k = 0; k < tests[i].reads; k++)
      begin
        if (tests[i].reads == 1)
          exp_adr = {tests[i].adr[31:2], 2'b00};
        else
          exp_adr = line_adr + adr_t'(4 * k);
        verify_adr({tests[i].name, "_ar"}, exp_adr, ar_log[base + k].addr);
        // AXI prot bit 2 marks an instruction access
        match_flag({tests[i].name, "_ar_instr"}, 1'b1, ar_log[base + k].prot[2]);
      end
      score_rsp(tests[i].name, tests[i].adr, tests[i].err, rsp);
      if (tests[i].reads == 0)
        compare_count({tests[i].name, "_latency"}, 2, lat);
    end

    // Pipelined hits on the refilled line
    base = ar_log.size();
    fetch_two_hits(32'h0000_1004, 32'h0000_1008, rsp, rsp_b);
    compare_count("back_to_back_reads", 0, ar_log.size() - base);
    score_rsp("back_to_back_first", 32'h0000_1004, 1'b0, rsp);
    score_rsp("back_to_back_second", 32'h0000_1008, 1'b0, rsp_b);

    if (sva_errs != 0)
    begin
      $display("Assertion failures seen: %0d", sva_errs);
      $display("** FAIL **");
      $fatal(1, "Run ended with assertion failures");
    end
    else
    begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* icache_top.f */
src/icache_pkg.sv
src/icache_lookup.sv
src/icache_mem.sv
src/icache_hit.sv
src/icache_fill.sv
src/icache_top.sv
verif/icache_sva.sv
verif/icache_tb.sv
